// File: all.f
+incdir+include
hw/sdram_pkg.sv
hw/sdram_timer.sv
hw/sdram_init.sv
hw/sdram_aref.sv
hw/sdram_access.sv
hw/sdram_arbit.sv
hw/sdram_top.sv
verif/sdram_chk.sv
verif/sdram_monitor.sv
verif/sdram_tb.sv

// File: hw/sdram_access.sv
`include "sdram_config.svh"

module sdram_access (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  sdram_pkg::wb_addr_t   wb_adr,
	input  logic [15:0]           wb_dat_w,
	output logic                  wb_ack,
	output logic [15:0]           wb_dat_r,
	output logic                  acc_req,
	input  logic                  acc_en,
	output sdram_pkg::sdram_bus_t acc_bus,
	output logic [15:0]           dq_out,
	output logic                  dq_oe,
	input  logic [15:0]           dq_in,
	output logic                  acc_done
);

	// Step numbers counted from the first granted cycle
	localparam logic [3:0] COL_STEP = 4'(`SDRAM_T_RCD);
	localparam logic [3:0] CAP_STEP = 4'(`SDRAM_T_RCD + `SDRAM_CAS);
	localparam logic [3:0] WR_DONE_STEP = 4'(`SDRAM_T_RCD + `SDRAM_T_WR);
	localparam logic [3:0] RD_DONE_STEP = 4'(`SDRAM_T_RCD + `SDRAM_CAS + 1);

	logic [3:0] step;
	logic [3:0] done_step;
	logic       ack_seen;

	assign done_step = wb_we ? WR_DONE_STEP : RD_DONE_STEP;
	assign acc_done = acc_en && (step == done_step);
	assign wb_ack = acc_done;
	assign acc_req = wb_cyc && wb_stb && !ack_seen && !wb_ack;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step <= '0;
		end else if (acc_en) begin
			step <= step + 4'd1;
		end else begin
			step <= '0;
		end
	end

	// Blocks a second request until the host ends the acked cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_seen <= 1'b0;
		end else if (wb_ack) begin
			ack_seen <= 1'b1;
		end else if (!(wb_cyc && wb_stb)) begin
			ack_seen <= 1'b0;
		end
	end

	// Write data registered so it lines up with WRITE on the pins
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dq_oe <= 1'b0;
			dq_out <= '0;
		end else begin
			dq_oe <= acc_en && wb_we && (step == COL_STEP);
			dq_out <= wb_dat_w;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_dat_r <= '0;
		end else if (acc_en && !wb_we && step == CAP_STEP) begin
			wb_dat_r <= dq_in;
		end
	end

	always_comb begin
		acc_bus = sdram_pkg::BUS_NOP;
		if (acc_en) begin
			if (step == 4'd0) begin
				acc_bus.cmd = sdram_pkg::ACTIVE;
				acc_bus.ban = wb_adr.ban;
				acc_bus.addr = wb_adr.row;
			end else if (step == COL_STEP) begin
				// Column access with auto-precharge
				acc_bus.cmd = wb_we ? sdram_pkg::WRITE : sdram_pkg::READ;
				acc_bus.ban = wb_adr.ban;
				acc_bus.addr = {4'b0010, wb_adr.col};
			end
		end
	end

endmodule

// File: hw/sdram_arbit.sv
module sdram_arbit (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  init_done,
	input  logic                  aref_req,
	input  logic                  aref_done,
	input  logic                  acc_req,
	input  logic                  acc_done,
	input  sdram_pkg::sdram_bus_t init_bus,
	input  sdram_pkg::sdram_bus_t aref_bus,
	input  sdram_pkg::sdram_bus_t acc_bus,
	output logic                  init_en,
	output logic                  aref_en,
	output logic                  acc_en,
	output sdram_pkg::sdram_bus_t sdram_bus
);

	typedef enum logic [3:0] {
		IDLE   = 4'b0001,
		ARBIT  = 4'b0010,
		AREF   = 4'b0100,
		ACCESS = 4'b1000
	} arb_state_t;

	arb_state_t            state;
	sdram_pkg::sdram_bus_t bus_sel;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (init_done) begin
						state <= ARBIT;
					end
				end
				ARBIT: begin
					// Refresh wins over a waiting host access
					if (aref_req) begin
						state <= AREF;
					end else if (acc_req) begin
						state <= ACCESS;
					end
				end
				AREF: begin
					if (aref_done) begin
						state <= ARBIT;
					end
				end
				ACCESS: begin
					if (acc_done) begin
						state <= ARBIT;
					end
				end
				default: begin
					state <= ARBIT;
				end
			endcase
		end
	end

	assign init_en = (state == IDLE);
	assign aref_en = (state == AREF);
	assign acc_en = (state == ACCESS);

	always_comb begin
		case (state)
			IDLE:    bus_sel = init_bus;
			AREF:    bus_sel = aref_bus;
			ACCESS:  bus_sel = acc_bus;
			default: bus_sel = sdram_pkg::BUS_NOP;
		endcase
	end

	// Pins change one cycle after the engine drives its command
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sdram_bus <= sdram_pkg::BUS_INHIBIT;
		end else begin
			sdram_bus <= bus_sel;
		end
	end

endmodule

// File: hw/sdram_aref.sv
`include "sdram_config.svh"

module sdram_aref (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  aref_en,
	output sdram_pkg::sdram_bus_t aref_bus,
	output logic                  aref_done
);

	localparam logic [3:0] DONE_STEP = 4'(`SDRAM_T_RFC);

	logic [3:0] step;

	// Restarts from zero on every grant
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step <= '0;
		end else if (aref_en) begin
			step <= step + 4'd1;
		end else begin
			step <= '0;
		end
	end

	assign aref_done = aref_en && (step == DONE_STEP);

	always_comb begin
		aref_bus = sdram_pkg::BUS_NOP;
		if (aref_en && step == 4'd0) begin
			aref_bus.cmd = sdram_pkg::AUTO_REFRESH;
		end
	end

endmodule

// File: hw/sdram_init.sv
`include "sdram_config.svh"

module sdram_init (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  init_wait_done,
	input  logic                  init_en,
	output sdram_pkg::sdram_bus_t init_bus,
	output logic                  init_done
);

	// Step numbers of each power-up command
	localparam logic [4:0] REF1_STEP = 5'(`SDRAM_T_RP);
	localparam logic [4:0] REF2_STEP = 5'(`SDRAM_T_RP + `SDRAM_T_RFC);
	localparam logic [4:0] MODE_STEP = 5'(`SDRAM_T_RP + 2 * `SDRAM_T_RFC);
	localparam logic [4:0] DONE_STEP = 5'(`SDRAM_T_RP + 2 * `SDRAM_T_RFC + `SDRAM_T_MRD);

	logic [4:0] step;
	logic       run;

	assign run = init_en & init_wait_done;
	assign init_done = run && (step == DONE_STEP);

	// Sequence runs once, so the counter parks at the last step
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step <= '0;
		end else if (run && step != DONE_STEP) begin
			step <= step + 5'd1;
		end
	end

	always_comb begin
		init_bus = sdram_pkg::BUS_NOP;
		if (run) begin
			case (step)
				5'd0: begin
					// All banks
					init_bus.cmd = sdram_pkg::PRECHARGE;
					init_bus.addr = 13'h0400;
				end
				REF1_STEP, REF2_STEP: begin
					init_bus.cmd = sdram_pkg::AUTO_REFRESH;
				end
				MODE_STEP: begin
					init_bus.cmd = sdram_pkg::LOAD_MODE;
					init_bus.addr = `SDRAM_MODE;
				end
				default: begin
					init_bus = sdram_pkg::BUS_NOP;
				end
			endcase
		end
	end

endmodule

// File: hw/sdram_pkg.sv
package sdram_pkg;

	// Bits ordered cs_n, ras_n, cas_n, we_n
	typedef enum logic [3:0] {
		LOAD_MODE    = 4'b0000,
		AUTO_REFRESH = 4'b0001,
		PRECHARGE    = 4'b0010,
		ACTIVE       = 4'b0011,
		WRITE        = 4'b0100,
		READ         = 4'b0101,
		NOP          = 4'b0111,
		INHIBIT      = 4'b1111
	} sdram_cmd_t;

	// One cycle of the command bus
	typedef struct packed {
		sdram_cmd_t  cmd;
		logic [1:0]  ban;
		logic [12:0] addr;
	} sdram_bus_t;

	// Host word address layout
	typedef struct packed {
		logic [1:0]  ban;
		logic [12:0] row;
		logic [8:0]  col;
	} wb_addr_t;

	localparam sdram_bus_t BUS_NOP = '{cmd: NOP, ban: 2'b00, addr: 13'd0};
	localparam sdram_bus_t BUS_INHIBIT = '{cmd: INHIBIT, ban: 2'b00, addr: 13'd0};

endpackage

// File: hw/sdram_timer.sv
`include "sdram_config.svh"

module sdram_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic aref_done,
	input  logic init_done,
	output logic init_wait_done,
	output logic aref_req
);

	localparam logic [15:0] WAIT_LAST = 16'(`SDRAM_INIT_WAIT - 1);
	localparam logic [15:0] REF_LAST = 16'(`SDRAM_REF_PERIOD - 1);
	// Refresh length and arbiter hop already count toward the next interval
	localparam logic [15:0] REF_RELOAD = 16'(`SDRAM_T_RFC + 2);

	logic [15:0] wait_cnt;
	logic [15:0] ref_cnt;
	logic        ref_run;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wait_cnt <= '0;
			init_wait_done <= 1'b0;
		end else if (!init_wait_done) begin
			wait_cnt <= wait_cnt + 16'd1;
			if (wait_cnt == WAIT_LAST) begin
				init_wait_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ref_run <= 1'b0;
			ref_cnt <= '0;
			aref_req <= 1'b0;
		end else if (init_done) begin
			ref_run <= 1'b1;
			ref_cnt <= '0;
		end else if (aref_done) begin
			aref_req <= 1'b0;
			ref_cnt <= REF_RELOAD;
		end else if (ref_run && !aref_req) begin
			// Request stays pending until the refresh engine reports done
			if (ref_cnt == REF_LAST) begin
				aref_req <= 1'b1;
			end else begin
				ref_cnt <= ref_cnt + 16'd1;
			end
		end
	end

endmodule

// File: hw/sdram_top.sv
module sdram_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                wb_cyc,
	input  logic                wb_stb,
	input  logic                wb_we,
	input  sdram_pkg::wb_addr_t wb_adr,
	input  logic [15:0]         wb_dat_w,
	output logic                wb_ack,
	output logic [15:0]         wb_dat_r,
	output logic                sdram_cke,
	output logic                sdram_cs_n,
	output logic                sdram_ras_n,
	output logic                sdram_cas_n,
	output logic                sdram_we_n,
	output logic [1:0]          sdram_ban,
	output logic [12:0]         sdram_addr,
	output logic [15:0]         dq_out,
	output logic                dq_oe,
	input  logic [15:0]         dq_in
);

	logic init_wait_done;
	logic init_done;
	logic init_en;
	logic aref_req;
	logic aref_done;
	logic aref_en;
	logic acc_req;
	logic acc_done;
	logic acc_en;

	sdram_pkg::sdram_bus_t init_bus;
	sdram_pkg::sdram_bus_t aref_bus;
	sdram_pkg::sdram_bus_t acc_bus;
	sdram_pkg::sdram_bus_t sdram_bus;

	// Clock enable rises with the first edge out of reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sdram_cke <= 1'b0;
		end else begin
			sdram_cke <= 1'b1;
		end
	end

	assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = sdram_bus.cmd;
	assign sdram_ban = sdram_bus.ban;
	assign sdram_addr = sdram_bus.addr;

	sdram_timer u_timer (
		.clk(clk), .rst_n(rst_n),
		.aref_done(aref_done), .init_done(init_done),
		.init_wait_done(init_wait_done), .aref_req(aref_req)
	);

	sdram_init u_init (
		.clk(clk), .rst_n(rst_n),
		.init_wait_done(init_wait_done), .init_en(init_en),
		.init_bus(init_bus), .init_done(init_done)
	);

	sdram_aref u_aref (
		.clk(clk), .rst_n(rst_n),
		.aref_en(aref_en), .aref_bus(aref_bus), .aref_done(aref_done)
	);

	sdram_access u_access (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
		.acc_req(acc_req), .acc_en(acc_en), .acc_bus(acc_bus),
		.dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in),
		.acc_done(acc_done)
	);

	sdram_arbit u_arbit (
		.clk(clk), .rst_n(rst_n),
		.init_done(init_done), .aref_req(aref_req), .aref_done(aref_done),
		.acc_req(acc_req), .acc_done(acc_done),
		.init_bus(init_bus), .aref_bus(aref_bus), .acc_bus(acc_bus),
		.init_en(init_en), .aref_en(aref_en), .acc_en(acc_en),
		.sdram_bus(sdram_bus)
	);

endmodule

// File: include/sdram_config.svh
`ifndef SDRAM_CONFIG_SVH
`define SDRAM_CONFIG_SVH

// Start-up wait before the first precharge, shortened for simulation
`define SDRAM_INIT_WAIT 200

// Cycles between auto-refresh commands
`define SDRAM_REF_PERIOD 390

// Core timing in clock cycles
`define SDRAM_T_RP 2
`define SDRAM_T_RFC 7
`define SDRAM_T_MRD 2
`define SDRAM_T_RCD 2
`define SDRAM_CAS 3

// Write recovery plus the auto-precharge that follows
`define SDRAM_T_WR 4

// Mode word with burst length 1, sequential, CAS 3
`define SDRAM_MODE 13'b000_0_00_011_0_000

`endif

// File: run.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module sdram_tb -f all.f -o sdram_sim

./obj_dir/sdram_sim +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log; then
	echo "Simulation reported failure, see sim.log"
	exit 1
fi

echo "Simulation finished without failure"

// File: verif/sdram_chk.sv
module sdram_chk (
	input logic clk,
	input logic rst_n,
	input logic wb_ack,
	input logic dq_oe,
	input logic sdram_cke,
	input logic sdram_cs_n,
	input logic sdram_ras_n,
	input logic sdram_cas_n,
	input logic sdram_we_n
);

	timeunit 1ns;
	timeprecision 100ps;

	logic is_write;
	int   ack_fails = 0;
	int   oe_fails = 0;
	int   cke_fails = 0;

	assign is_write = ({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} == sdram_pkg::WRITE);

	// Ack lasts one cycle per transfer
	ack_single: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
		else begin
			$error("wb_ack stayed high for two cycles in a row");
			ack_fails++;
		end

	// Write data may lead the registered WRITE on the pins by one cycle
	oe_in_write: assert property (@(posedge clk) disable iff (!rst_n)
		$past(dq_oe) |-> (is_write || $past(is_write)))
		else begin
			$error("dq_oe driven outside a WRITE cycle");
			oe_fails++;
		end

	cke_high: assert property (@(posedge clk) disable iff (!rst_n)
		($past(rst_n) && $past(rst_n, 2)) |-> sdram_cke)
		else begin
			$error("sdram_cke low after reset release");
			cke_fails++;
		end

endmodule

// File: verif/sdram_monitor.sv
`include "sdram_config.svh"

module sdram_monitor (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  sdram_pkg::wb_addr_t   wb_adr,
	input  logic [15:0]           wb_dat_w,
	input  logic                  wb_ack,
	input  logic [15:0]           wb_dat_r,
	input  sdram_pkg::sdram_bus_t pins,
	output int                    err_cnt,
	output int                    ack_cnt,
	output int                    rd_checked
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ACC_CYCLES = 2 + `SDRAM_T_RCD + `SDRAM_CAS + `SDRAM_T_WR + 2;
	localparam int REF_GAP_MAX = `SDRAM_REF_PERIOD + ACC_CYCLES;
	// Power-up commands and the gap in cycles before each
	localparam sdram_pkg::sdram_cmd_t INIT_CMDS [4] = '{sdram_pkg::PRECHARGE,
		sdram_pkg::AUTO_REFRESH, sdram_pkg::AUTO_REFRESH, sdram_pkg::LOAD_MODE};
	localparam int INIT_GAPS [4] = '{0, `SDRAM_T_RP, `SDRAM_T_RFC, `SDRAM_T_RFC};

	sdram_pkg::sdram_cmd_t cmd;
	logic [23:0]           adr_key;
	logic [15:0]           ref_mem [logic [23:0]];
	int                    cyc;
	int                    init_step;
	int                    last_init_cyc;
	int                    last_ref_cyc;
	logic                  ref_late;
	logic                  act_open;
	int                    act_cyc;
	logic [1:0]            act_ban;
	logic                  col_seen;

	assign cmd = pins.cmd;
	assign adr_key = wb_adr;

	task report_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("ERROR at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
		err_cnt++;
	endtask

	task report_fault(input string msg);
		$display("Check failed at %0t ns: %s", $time, msg);
		err_cnt++;
	endtask

	task check_init;
		sdram_pkg::sdram_cmd_t exp_cmd;
		exp_cmd = INIT_CMDS[init_step];
		if (cmd == sdram_pkg::NOP || cmd == sdram_pkg::INHIBIT) begin
			return;
		end
		if (cmd != exp_cmd) begin
			report_fault($sformatf("%s issued where init expects %s", cmd.name(), exp_cmd.name()));
			return;
		end
		if (init_step > 0 && cyc - last_init_cyc != INIT_GAPS[init_step]) begin
			report_fault($sformatf("%s came %0d cycles after the previous init command, not %0d",
				cmd.name(), cyc - last_init_cyc, INIT_GAPS[init_step]));
		end
		if (init_step == 0 && !pins.addr[10]) begin
			report_fault("init PRECHARGE does not address all banks");
		end
		if (init_step == 3 && pins.addr != `SDRAM_MODE) begin
			report_mismatch("sdram_addr", 32'(pins.addr), 32'(`SDRAM_MODE));
		end
		last_init_cyc = cyc;
		init_step++;
		last_ref_cyc = cyc;
	endtask

	task check_refresh;
		if (cmd == sdram_pkg::AUTO_REFRESH) begin
			last_ref_cyc = cyc;
			ref_late = 1'b0;
		end else if (!ref_late && cyc - last_ref_cyc > REF_GAP_MAX) begin
			report_fault($sformatf("no AUTO_REFRESH within %0d cycles", REF_GAP_MAX));
			ref_late = 1'b1;
		end
	endtask

	task check_access;
		case (cmd)
			sdram_pkg::ACTIVE: begin
				if (act_open || col_seen) begin
					report_fault("ACTIVE issued again before the transfer was acked");
				end
				if (!(wb_cyc && wb_stb)) begin
					report_fault("ACTIVE issued with no transfer pending");
				end else begin
					if (pins.ban != wb_adr.ban) begin
						report_mismatch("sdram_ban", 32'(pins.ban), 32'(wb_adr.ban));
					end
					if (pins.addr != wb_adr.row) begin
						report_mismatch("sdram_addr", 32'(pins.addr), 32'(wb_adr.row));
					end
				end
				act_open = 1'b1;
				act_cyc = cyc;
				act_ban = pins.ban;
			end
			sdram_pkg::WRITE, sdram_pkg::READ: begin
				if (!act_open) begin
					report_fault($sformatf("%s issued without a preceding ACTIVE", cmd.name()));
				end else begin
					if (cyc - act_cyc < `SDRAM_T_RCD) begin
						report_fault($sformatf("%s only %0d cycles after ACTIVE",
							cmd.name(), cyc - act_cyc));
					end
					if (!pins.addr[10]) begin
						report_fault($sformatf("%s without auto-precharge", cmd.name()));
					end
					if (pins.ban != act_ban) begin
						report_mismatch("sdram_ban", 32'(pins.ban), 32'(act_ban));
					end
					if (pins.addr[8:0] != wb_adr.col) begin
						report_mismatch("sdram_addr", 32'(pins.addr[8:0]), 32'(wb_adr.col));
					end
					if ((cmd == sdram_pkg::WRITE) != wb_we) begin
						report_fault($sformatf("%s does not match wb_we", cmd.name()));
					end
				end
				act_open = 1'b0;
				col_seen = 1'b1;
			end
			sdram_pkg::PRECHARGE, sdram_pkg::LOAD_MODE: begin
				report_fault($sformatf("%s issued after init", cmd.name()));
			end
			default: begin
			end
		endcase
	endtask

	task check_ack;
		if (!wb_ack) begin
			return;
		end
		ack_cnt++;
		if (!(wb_cyc && wb_stb)) begin
			report_fault("wb_ack with no transfer pending");
		end else begin
			if (!col_seen) begin
				report_fault("transfer acked without a WRITE or READ");
			end
			if (wb_we) begin
				ref_mem[adr_key] = wb_dat_w;
			end else if (ref_mem.exists(adr_key)) begin
				rd_checked++;
				if (wb_dat_r != ref_mem[adr_key]) begin
					report_mismatch("wb_dat_r", 32'(wb_dat_r), 32'(ref_mem[adr_key]));
				end
			end
		end
		act_open = 1'b0;
		col_seen = 1'b0;
	endtask

	// Mid-cycle sampling keeps every check clear of the clock edge
	always @(negedge clk) begin
		if (!rst_n) begin
			err_cnt = 0;
			ack_cnt = 0;
			rd_checked = 0;
			cyc = 0;
			init_step = 0;
			last_init_cyc = 0;
			last_ref_cyc = 0;
			ref_late = 1'b0;
			act_open = 1'b0;
			act_cyc = 0;
			act_ban = 2'b00;
			col_seen = 1'b0;
		end else begin
			cyc++;
			if (init_step < 4) begin
				check_init();
			end else begin
				check_refresh();
				check_access();
			end
			check_ack();
		end
	end

endmodule

// File: verif/sdram_tb.sv
`include "sdram_config.svh"

module sdram_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 8;
	localparam int NUM_RANDOM = 300;
	localparam int NUM_XFERS = NUM_RANDOM + 2;
	localparam int MAX_GAP = 6;
	localparam int ACC_CYCLES = 2 + `SDRAM_T_RCD + `SDRAM_CAS + `SDRAM_T_WR + 2;
	localparam int INIT_CYCLES = 16 + `SDRAM_INIT_WAIT + `SDRAM_T_RP + 2 * `SDRAM_T_RFC
		+ `SDRAM_T_MRD;
	// Each transfer may wait behind one refresh
	localparam int XFER_WORST = ACC_CYCLES + `SDRAM_T_RFC + 3 + MAX_GAP;
	localparam int LIMIT_CYCLES = INIT_CYCLES + NUM_XFERS * XFER_WORST;

	logic                  clk = 1'b0;
	logic                  rst_n = 1'b0;
	logic                  wb_cyc = 1'b0;
	logic                  wb_stb = 1'b0;
	logic                  wb_we = 1'b0;
	sdram_pkg::wb_addr_t   wb_adr = '0;
	logic [15:0]           wb_dat_w = '0;
	logic                  wb_ack;
	logic [15:0]           wb_dat_r;
	logic                  sdram_cke;
	logic                  sdram_cs_n;
	logic                  sdram_ras_n;
	logic                  sdram_cas_n;
	logic                  sdram_we_n;
	logic [1:0]            sdram_ban;
	logic [12:0]           sdram_addr;
	logic [15:0]           dq_out;
	logic                  dq_oe;
	logic [15:0]           dq_in = '0;
	sdram_pkg::sdram_bus_t pin_bus;

	logic [31:0]         rng;
	int                  xfer_cnt;
	int                  mon_errs;
	int                  ack_cnt;
	int                  rd_checked;
	sdram_pkg::wb_addr_t addr_pool [8];

	// Memory model state
	logic [12:0] open_row [4];
	logic [15:0] sdram_mem [logic [23:0]];
	logic [15:0] rd_word;
	int          rd_wait;
	logic        wr_pend;
	logic [23:0] wr_key;
	logic [23:0] rd_key;

	assign pin_bus = {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n, sdram_ban, sdram_addr};

	sdram_top DUT (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
		.sdram_cke(sdram_cke), .sdram_cs_n(sdram_cs_n), .sdram_ras_n(sdram_ras_n),
		.sdram_cas_n(sdram_cas_n), .sdram_we_n(sdram_we_n),
		.sdram_ban(sdram_ban), .sdram_addr(sdram_addr),
		.dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in)
	);

	sdram_monitor u_monitor (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.wb_ack(wb_ack), .wb_dat_r(wb_dat_r), .pins(pin_bus),
		.err_cnt(mon_errs), .ack_cnt(ack_cnt), .rd_checked(rd_checked)
	);

	bind sdram_top sdram_chk u_chk (
		.clk(clk), .rst_n(rst_n), .wb_ack(wb_ack), .dq_oe(dq_oe), .sdram_cke(sdram_cke),
		.sdram_cs_n(sdram_cs_n), .sdram_ras_n(sdram_ras_n),
		.sdram_cas_n(sdram_cas_n), .sdram_we_n(sdram_we_n)
	);

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] next_random(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// One Wishbone classic cycle, held until ack
	task automatic wb_transfer(input logic we, input sdram_pkg::wb_addr_t adr,
		input logic [15:0] dat);
		@(posedge clk);
		#1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = dat;
		@(negedge clk);
		while (!wb_ack) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		xfer_cnt++;
	endtask

	// SDRAM model, latches commands mid-cycle and holds read data until the next read
	always @(negedge clk) begin
		if (!rst_n) begin
			rd_wait = 0;
			wr_pend = 1'b0;
			dq_in = '0;
		end else begin
			if (rd_wait > 0) begin
				if (rd_wait == 1) begin
					dq_in = rd_word;
				end
				rd_wait--;
			end
			if (wr_pend && dq_oe) begin
				sdram_mem[wr_key] = dq_out;
				wr_pend = 1'b0;
			end
			case (pin_bus.cmd)
				sdram_pkg::ACTIVE: begin
					open_row[pin_bus.ban] = pin_bus.addr;
				end
				sdram_pkg::WRITE: begin
					wr_key = {pin_bus.ban, open_row[pin_bus.ban], pin_bus.addr[8:0]};
					if (dq_oe) begin
						sdram_mem[wr_key] = dq_out;
						wr_pend = 1'b0;
					end else begin
						wr_pend = 1'b1;
					end
				end
				sdram_pkg::READ: begin
					rd_key = {pin_bus.ban, open_row[pin_bus.ban], pin_bus.addr[8:0]};
					rd_word = sdram_mem.exists(rd_key) ? sdram_mem[rd_key] : 16'h0000;
					rd_wait = `SDRAM_CAS - 1;
				end
				default: begin
				end
			endcase
		end
	end

	initial begin
		sdram_pkg::wb_addr_t adr;
		logic [15:0]         dat;
		logic                we;
		logic                wild;
		int                  gap;
		int                  total_errs;
		rng = 32'h8ba2_4ca0;
		xfer_cnt = 0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// Small address pool so that reads hit earlier writes
		for (int k = 0; k < 8; k++) begin
			rng = next_random(rng);
			addr_pool[k] = rng[23:0];
		end
		wb_transfer(1'b1, addr_pool[0], 16'hA5C3);
		wb_transfer(1'b0, addr_pool[0], 16'h0000);
		for (int i = 0; i < NUM_RANDOM; i++) begin
			rng = next_random(rng);
			we = rng[0];
			adr = addr_pool[rng[3:1]];
			wild = (rng[7:4] == 4'd0);
			gap = int'(rng[10:8]) % MAX_GAP + 1;
			rng = next_random(rng);
			dat = rng[15:0];
			if (wild) begin
				adr = rng[31:8];
			end
			wb_transfer(we, adr, dat);
			repeat (gap) @(posedge clk);
		end
		repeat (4) @(posedge clk);
		total_errs = mon_errs + DUT.u_chk.ack_fails + DUT.u_chk.oe_fails + DUT.u_chk.cke_fails;
		if (ack_cnt != xfer_cnt) begin
			$display("Ack count %0d does not match the %0d transfers issued", ack_cnt, xfer_cnt);
			total_errs++;
		end
		$display("Summary: %0d transfers, %0d acks, %0d reads checked, %0d errors",
			xfer_cnt, ack_cnt, rd_checked, total_errs);
		if (total_errs == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
		$display("Verification failed");
		$finish;
	end

endmodule
